// ==== verilog/rv_core_macros.svh ====
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Widths fixed by RV32I
`define RV_XLEN          32
`define RV_REG_ADDR_W    5
`define RV_ALU_OP_W      4

// Major opcodes handled by the core
`define RV_OPC_LUI       7'b011_0111
`define RV_OPC_OP_IMM    7'b001_0011
`define RV_OPC_OP        7'b011_0011

// funct3 values shared by OP and OP-IMM
`define RV_F3_ADD_SUB    3'b000
`define RV_F3_SLL        3'b001
`define RV_F3_SLT        3'b010
`define RV_F3_SLTU       3'b011
`define RV_F3_XOR        3'b100
`define RV_F3_SRL_SRA    3'b101
`define RV_F3_OR         3'b110
`define RV_F3_AND        3'b111

// ALU operation codes
`define ALU_NOP          4'd0    // Bubble, result forced to zero
`define ALU_ADD          4'd1
`define ALU_SUB          4'd2
`define ALU_SLL          4'd3
`define ALU_SLT          4'd4
`define ALU_SLTU         4'd5
`define ALU_XOR          4'd6
`define ALU_SRL          4'd7
`define ALU_SRA          4'd8
`define ALU_OR           4'd9
`define ALU_AND          4'd10

`endif

// ==== verilog/rv_core_pkg.sv ====
`default_nettype none

`include "rv_core_macros.svh"

// Types shared by the datapath modules and the testbench
package rv_core_pkg;

    // One data word, also used for a raw instruction
    typedef logic [`RV_XLEN-1:0] word_t;

    // Index into the 32-entry register file
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [`RV_ALU_OP_W-1:0] alu_op_t;   // See ALU_* codes in the macro header

endpackage

`default_nettype wire

// ==== verilog/instruction_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_macros.svh"

module instruction_decode (
    input  rv_core_pkg::word_t     instr,
    input  logic                   instr_valid,
    output rv_core_pkg::reg_addr_t rs1_addr,
    output rv_core_pkg::reg_addr_t rs2_addr,
    output rv_core_pkg::reg_addr_t rd_addr,
    output rv_core_pkg::word_t     imm,
    output logic                   use_imm,
    output rv_core_pkg::alu_op_t   alu_op,
    output logic                   wb_en
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt_bit;        // Bit 30 picks SUB and SRA
    logic       known;          // Opcode and function combination recognised
    alu_op_t    op_sel;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_shamt;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign alt_bit = instr[30];

    assign imm_i     = {{20{instr[31]}}, instr[31:20]};   // Sign extended I type
    assign imm_u     = {instr[31:12], 12'd0};             // LUI upper immediate
    assign imm_shamt = {27'd0, instr[24:20]};             // Shift amount only

    always_comb begin
        // Inactive defaults, same as a bubble
        known    = 1'b0;
        op_sel   = `ALU_NOP;
        rs1_addr = '0;
        rs2_addr = '0;
        rd_addr  = '0;
        imm      = '0;
        use_imm  = 1'b0;

        case (opcode)
            `RV_OPC_LUI: begin
                known   = 1'b1;
                rd_addr = instr[11:7];
                imm     = imm_u;      // rs1 stays x0 so A is zero
                use_imm = 1'b1;
                op_sel  = `ALU_ADD;
            end
            `RV_OPC_OP_IMM: begin   // ADDI .. SRAI
                known    = 1'b1;
                rd_addr  = instr[11:7];
                rs1_addr = instr[19:15];
                imm      = imm_i;
                use_imm  = 1'b1;
                case (funct3)
                    `RV_F3_ADD_SUB: op_sel = `ALU_ADD;
                    `RV_F3_SLT:     op_sel = `ALU_SLT;
                    `RV_F3_SLTU:    op_sel = `ALU_SLTU;
                    `RV_F3_XOR:     op_sel = `ALU_XOR;
                    `RV_F3_OR:      op_sel = `ALU_OR;
                    `RV_F3_AND:     op_sel = `ALU_AND;
                    `RV_F3_SLL: begin
                        op_sel = `ALU_SLL;
                        imm    = imm_shamt;
                        known  = !alt_bit;     // No arithmetic left shift
                    end
                    `RV_F3_SRL_SRA: begin
                        op_sel = alt_bit ? `ALU_SRA : `ALU_SRL;
                        imm    = imm_shamt;
                    end
                    default: known = 1'b0;
                endcase
            end
            `RV_OPC_OP: begin   // ADD .. AND
                known    = 1'b1;
                rd_addr  = instr[11:7];
                rs1_addr = instr[19:15];
                rs2_addr = instr[24:20];
                case (funct3)
                    `RV_F3_ADD_SUB: op_sel = alt_bit ? `ALU_SUB : `ALU_ADD;
                    `RV_F3_SRL_SRA: op_sel = alt_bit ? `ALU_SRA : `ALU_SRL;
                    `RV_F3_SLL:     op_sel = `ALU_SLL;
                    `RV_F3_SLT:     op_sel = `ALU_SLT;
                    `RV_F3_SLTU:    op_sel = `ALU_SLTU;
                    `RV_F3_XOR:     op_sel = `ALU_XOR;
                    `RV_F3_OR:      op_sel = `ALU_OR;
                    `RV_F3_AND:     op_sel = `ALU_AND;
                    default:        known  = 1'b0;
                endcase
                // Bit 30 only legal on the ADD/SUB and SRL/SRA slices
                if (alt_bit && funct3 != `RV_F3_ADD_SUB && funct3 != `RV_F3_SRL_SRA) begin
                    known = 1'b0;
                end
            end
            default: begin
                known = 1'b0;   // Bubble or unsupported opcode
            end
        endcase

        wb_en = instr_valid && known;

        // Anything not issued flows down as a bubble
        if (!wb_en) begin
            rs1_addr = '0;
            rs2_addr = '0;
            rd_addr  = '0;
            imm      = '0;
            use_imm  = 1'b0;
            op_sel   = `ALU_NOP;
        end

        alu_op = op_sel;
    end

endmodule

`default_nettype wire

// ==== verilog/operand_forward.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_forward (
    input  rv_core_pkg::reg_addr_t rs1_addr,
    input  rv_core_pkg::reg_addr_t rs2_addr,
    input  rv_core_pkg::word_t     rs1_data,
    input  rv_core_pkg::word_t     rs2_data,
    input  rv_core_pkg::reg_addr_t ex_rd,      // Instruction N-1
    input  logic                   ex_wb_en,
    input  rv_core_pkg::word_t     ex_result,  // Straight from the ALU
    input  rv_core_pkg::reg_addr_t wb_rd,      // Instruction N-2
    input  logic                   wb_en,
    input  rv_core_pkg::word_t     wb_result,
    output rv_core_pkg::word_t     op_a,
    output rv_core_pkg::word_t     op_b
);

    logic ex_live;     // N-1 will write a real register
    logic wb_live;     // N-2 will write a real register
    logic rs1_hit_ex;
    logic rs1_hit_wb;
    logic rs2_hit_ex;
    logic rs2_hit_wb;

    // x0 never forwards, its value is always zero
    assign ex_live = ex_wb_en && (ex_rd != '0);
    assign wb_live = wb_en && (wb_rd != '0);

    assign rs1_hit_ex = ex_live && (rs1_addr == ex_rd);
    assign rs1_hit_wb = wb_live && (rs1_addr == wb_rd);
    assign rs2_hit_ex = ex_live && (rs2_addr == ex_rd);
    assign rs2_hit_wb = wb_live && (rs2_addr == wb_rd);

    // Newest value wins, each source resolved on its own
    assign op_a = rs1_hit_ex ? ex_result :
                  rs1_hit_wb ? wb_result : rs1_data;
    assign op_b = rs2_hit_ex ? ex_result :
                  rs2_hit_wb ? wb_result : rs2_data;

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::reg_addr_t rs1_addr,
    input  rv_core_pkg::reg_addr_t rs2_addr,
    input  logic                   we,
    input  rv_core_pkg::reg_addr_t wr_addr,
    input  rv_core_pkg::word_t     wr_data,
    output rv_core_pkg::word_t     rs1_data,
    output rv_core_pkg::word_t     rs2_data
);
    import rv_core_pkg::*;

    word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;   // Writes to x0 dropped
        end
    end

    // Asynchronous reads
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_macros.svh"

module alu (
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    input  rv_core_pkg::alu_op_t op,
    output rv_core_pkg::word_t   result
);

    logic [4:0] shamt;       // Only low five bits count in RV32I
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            `ALU_ADD:  result = a + b;
            `ALU_SUB:  result = a - b;
            `ALU_SLL:  result = a << shamt;
            `ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            `ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            `ALU_XOR:  result = a ^ b;
            `ALU_SRL:  result = a >> shamt;
            `ALU_SRA:  result = $signed(a) >>> shamt;   // Sign bit fills from the left
            `ALU_OR:   result = a | b;
            `ALU_AND:  result = a & b;
            default:   result = '0;   // ALU_NOP and spare codes
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rv_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_core_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  rv_core_pkg::word_t     instr,
    output logic                   wb_valid,   // One cycle per retired write
    output rv_core_pkg::reg_addr_t wb_rd,
    output rv_core_pkg::word_t     wb_data
);
    import rv_core_pkg::*;

    // Decode stage
    reg_addr_t dec_rs1_addr;
    reg_addr_t dec_rs2_addr;
    reg_addr_t dec_rd;
    word_t     dec_imm;
    logic      dec_use_imm;
    alu_op_t   dec_alu_op;
    logic      dec_wb_en;
    word_t     rf_rs1_data;
    word_t     rf_rs2_data;
    word_t     fwd_a;
    word_t     fwd_b;
    word_t     ex_b_next;

    // Execute stage
    word_t     ex_a;
    word_t     ex_b;
    alu_op_t   ex_alu_op;
    reg_addr_t ex_rd;
    logic      ex_wb_en;
    word_t     ex_result;

    instruction_decode i_decode (
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs1_addr    (dec_rs1_addr),
        .rs2_addr    (dec_rs2_addr),
        .rd_addr     (dec_rd),
        .imm         (dec_imm),
        .use_imm     (dec_use_imm),
        .alu_op      (dec_alu_op),
        .wb_en       (dec_wb_en)
    );

    // Write port fed straight from the write-back stage
    register_file i_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (dec_rs1_addr),
        .rs2_addr (dec_rs2_addr),
        .we       (wb_valid),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    operand_forward i_forward (
        .rs1_addr  (dec_rs1_addr),
        .rs2_addr  (dec_rs2_addr),
        .rs1_data  (rf_rs1_data),
        .rs2_data  (rf_rs2_data),
        .ex_rd     (ex_rd),
        .ex_wb_en  (ex_wb_en),
        .ex_result (ex_result),
        .wb_rd     (wb_rd),
        .wb_en     (wb_valid),
        .wb_result (wb_data),
        .op_a      (fwd_a),
        .op_b      (fwd_b)
    );

    assign ex_b_next = dec_use_imm ? dec_imm : fwd_b;   // Immediate replaces rs2

    // Stage valid flags and ALU code
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_wb_en  <= 1'b0;
            ex_alu_op <= `ALU_NOP;
            wb_valid  <= 1'b0;
        end else begin
            ex_wb_en  <= dec_wb_en;
            ex_alu_op <= dec_alu_op;
            wb_valid  <= ex_wb_en;
        end
    end

    // Operands, destinations and result
    always_ff @(posedge clk) begin
        ex_a    <= fwd_a;
        ex_b    <= ex_b_next;
        ex_rd   <= dec_rd;
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

    alu i_alu (
        .a      (ex_a),
        .b      (ex_b),
        .op     (ex_alu_op),
        .result (ex_result)
    );

endmodule

`default_nettype wire

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int DRAIN_CYCLES = 50;   // Limit for the final drain
    localparam int LATENCY      = 3;    // Issue edge to the edge that samples the result

    logic      clk;
    logic      reset;
    logic      instr_valid;
    word_t     instr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // Program as read from the golden file
    word_t     prog_instr [$];
    logic      prog_flag  [$];
    reg_addr_t prog_rd    [$];
    word_t     prog_data  [$];

    // Issued slots waiting for their write-back edge
    int        exp_cycle [$];
    word_t     exp_instr [$];
    logic      exp_flag  [$];
    reg_addr_t exp_rd    [$];
    word_t     exp_data  [$];

    int        cycle_count = 0;   // Rising edges seen so far
    int        checked     = 0;

    rv_core_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always #10 clk = ~clk;   // 20 ns period

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_flag(input logic got, input logic exp, input word_t ins);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: wb_valid %b, expected %b (instr %h)", $time, got, exp, ins);
            stop_with_failure();
        end
    endtask

    task automatic check_rd(input reg_addr_t got, input reg_addr_t exp, input word_t ins);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: wb_rd x%0d, expected x%0d (instr %h)", $time, got, exp, ins);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp, input word_t ins);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: wb_data %h, expected %h (instr %h)", $time, got, exp, ins);
            stop_with_failure();
        end
    endtask

    // One slot per non-comment line
    task automatic load_golden();
        int    fd;
        int    fields;
        string line;
        word_t ins;
        int    flag;
        int    rd;
        word_t data;
        fd = $fopen("verification/rv_core_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file verification/rv_core_golden.txt");
            stop_with_failure();
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %d %d %h", ins, flag, rd, data);
                    if (fields != 4) begin
                        $display("Malformed golden line: %s", line);
                        stop_with_failure();
                    end else begin
                        prog_instr.push_back(ins);
                        prog_flag.push_back(flag != 0);
                        prog_rd.push_back(reg_addr_t'(rd));
                        prog_data.push_back(data);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Registered outputs, read at the edge that closes their cycle
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (reset === 1'b0) begin
            if (exp_cycle.size() != 0 && exp_cycle[0] + LATENCY == cycle_count) begin
                check_flag(wb_valid, exp_flag[0], exp_instr[0]);
                if (exp_flag[0]) begin   // rd and data only mean something on a write
                    check_rd(wb_rd, exp_rd[0], exp_instr[0]);
                    check_data(wb_data, exp_data[0], exp_instr[0]);
                end
                void'(exp_cycle.pop_front());
                void'(exp_instr.pop_front());
                void'(exp_flag.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                checked = checked + 1;
            end else begin
                check_flag(wb_valid, 1'b0, '0);   // Nothing due this cycle
            end
        end
    end

    initial begin
        int wait_cycles;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        load_golden();
        if (prog_instr.size() == 0) begin
            $display("The golden file holds no instructions");
            stop_with_failure();
        end
        repeat (4) @(posedge clk);   // Reset held for 4 cycles
        #1;
        reset = 1'b0;

        // One slot per cycle, zero word means no strobe
        foreach (prog_instr[i]) begin
            @(posedge clk);
            #1;
            instr_valid = (prog_instr[i] != '0);
            instr       = prog_instr[i];
            exp_cycle.push_back(cycle_count);
            exp_instr.push_back(prog_instr[i]);
            exp_flag.push_back(prog_flag[i]);
            exp_rd.push_back(prog_rd[i]);
            exp_data.push_back(prog_data[i]);
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = '0;

        // Drain, each poll just after the monitor has run
        wait_cycles = 0;
        while (exp_cycle.size() != 0 && wait_cycles < DRAIN_CYCLES) begin
            @(posedge clk);
            #2;
            wait_cycles = wait_cycles + 1;
        end
        if (exp_cycle.size() != 0) begin
            $display("Timeout: the pipeline never retired its instructions");
            stop_with_failure();
        end else begin
            $display("Compared %0d issue slots", checked);
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/instruction_decode.sv
verilog/operand_forward.sv
verilog/register_file.sv
verilog/alu.sv
verilog/rv_core_top.sv
verification/rv_core_tb.sv

// ==== verification/rv_core_golden.txt ====
# instr(hex) wb_flag rd(dec) wb_data(hex), one issue slot per line
# instr 00000000 is an idle slot with no strobe
123450B7 1 1 12345000   # lui   x1, 0x12345
FFB00113 1 2 FFFFFFFB   # addi  x2, x0, -5
7FF08193 1 3 123457FF   # addi  x3, x1, 0x7ff
00310233 1 4 123457FA   # add   x4, x2, x3
404102B3 1 5 EDCBA801   # sub   x5, x2, x4
00112333 1 6 00000001   # slt   x6, x2, x1
001133B3 1 7 00000000   # sltu  x7, x2, x1
FFF0A413 1 8 00000000   # slti  x8, x1, -1
FFF0B493 1 9 00000001   # sltiu x9, x1, -1
FFF1C513 1 10 EDCBA800  # xori  x10, x3, -1
0FF0E593 1 11 123450FF  # ori   x11, x1, 0xff
0F01F613 1 12 000000F0  # andi  x12, x3, 0xf0
00411693 1 13 FFFFFFB0  # slli  x13, x2, 4
00415713 1 14 0FFFFFFF  # srli  x14, x2, 4
40415793 1 15 FFFFFFFF  # srai  x15, x2, 4
00000000 0 0 00000000   # idle slot
00919833 1 16 2468AFFE  # sll   x16, x3, x9
000000EF 0 0 00000000   # jal x1, not decoded
00D158B3 1 17 0000FFFF  # srl   x17, x2, x13
40D15933 1 18 FFFFFFFF  # sra   x18, x2, x13
40D14933 0 0 00000000   # xor with funct7 0x20, invalid
00A949B3 1 19 123457FF  # xor   x19, x18, x10
00E0EA33 1 20 1FFFFFFF  # or    x20, x1, x14
00A2FAB3 1 21 EDCBA800  # and   x21, x5, x10
00108013 1 0 12345001   # addi  x0, x1, 1
00000B33 1 22 00000000  # add   x22, x0, x0
12300B93 1 23 00000123  # addi  x23, x0, 0x123
01700C33 1 24 00000123  # add   x24, x0, x23
